// File: rtl/addressMapPkg.sv
`default_nettype none

package addressMapPkg;

    // Processor bus widths
    typedef logic [11:0] regAddrT;
    typedef logic [15:0] busDataT;
    typedef logic [31:0] regWordT;
    typedef logic [7:0]  spaceTagT;
    typedef logic [3:0]  regOffsetT;

    //********************
    // Space tags, address bits 11 to 4
    //********************
    localparam spaceTagT miscSpaceTag = 8'h70;
    localparam spaceTagT modeSpaceTag = 8'h71;

    // Misc space offsets
    localparam regOffsetT miscResetOffset   = 4'h0;
    localparam regOffsetT miscVersionOffset = 4'h4;
    localparam regOffsetT miscClockOffset   = 4'h8;

    // Mode space offsets
    localparam regOffsetT modeOffset   = 4'h0;
    localparam regOffsetT dacSelOffset = 4'h4;

    // Register offset with the half select bit masked off
    function automatic regOffsetT offsetOf(regAddrT a);
        return {a[3:2], 2'b00};
    endfunction

endpackage

`default_nettype wire

// File: rtl/demodModePkg.sv
`default_nettype none

package demodModePkg;

    typedef enum logic [3:0] {
        modeLegacy     = 4'd0,
        modePcmTrellis = 4'd1,
        modeSoqpsk     = 4'd2,
        modeMultiH     = 4'd3
    } demodModeT;

    typedef logic [3:0] dacSelT;

    //********************
    // DAC source codes owned by the trellis decoders
    //********************
    localparam dacSelT dacTrellisI     = 4'd8;
    localparam dacSelT dacTrellisQ     = 4'd9;
    localparam dacSelT dacTrellisPhErr = 4'd10;
    localparam dacSelT dacTrellisIndex = 4'd11;

    // Sample paths
    typedef logic signed [17:0] sampleT;
    typedef logic [13:0]        dacWordT;

endpackage

`default_nettype wire

// File: rtl/busDecode.sv
`default_nettype none

module busDecode import addressMapPkg::*; (
    input  logic    ck933,
    input  logic    clockCounterEn,
    input  logic    nCs,
    input  logic    nWe,
    input  logic    nRd,
    input  regAddrT addr,
    input  busDataT dataIn,
    output regAddrT regAddr,
    output busDataT wrData,
    output logic    miscSel,
    output logic    modeSel,
    output logic    wrPulse,
    output logic    miscAccessStart,
    output logic    resetReadStart,
    output logic    rdActive
);

    logic     nCsR;
    logic     nWeR;
    logic     nRdR;
    logic     nCsD;
    logic     nWeD;
    logic     miscAccess;
    logic     miscAccessD;
    spaceTagT spaceTag;

    // Strobe reclock plus previous-cycle copies
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            nCsR        <= 1'b1;
            nWeR        <= 1'b1;
            nRdR        <= 1'b1;
            nCsD        <= 1'b1;
            nWeD        <= 1'b1;
            miscAccessD <= 1'b0;
        end else begin
            nCsR        <= nCs;
            nWeR        <= nWe;
            nRdR        <= nRd;
            nCsD        <= nCsR;
            nWeD        <= nWeR;
            miscAccessD <= miscAccess;
        end
    end

    // Address and write data reclock
    always_ff @(posedge ck933) begin
        regAddr <= addr;
        wrData  <= dataIn;
    end

    //********************
    // Space decode
    //********************
    assign spaceTag = regAddr[11:4];
    assign miscSel  = (spaceTag == miscSpaceTag);
    assign modeSel  = (spaceTag == modeSpaceTag);

    // Rising edge of nWe inside a chip select
    assign wrPulse = nWeR & ~nWeD & ~nCsD;

    assign miscAccess      = ~nCsR & miscSel;
    assign miscAccessStart = miscAccess & ~miscAccessD;
    assign resetReadStart  = miscAccessStart & ~nRdR
                           & (offsetOf(regAddr) == miscResetOffset);
    assign rdActive        = ~nCsR & ~nRdR;

endmodule

`default_nettype wire

// File: rtl/miscSpace.sv
`default_nettype none

module miscSpace import addressMapPkg::*; #(
    parameter busDataT    versionNumber = 16'h00c2,
    parameter logic [2:0] resetStretch  = 3'd6
) (
    input  logic    ck933,
    input  logic    clockCounterEn,
    input  regAddrT regAddr,
    input  busDataT wrData,
    input  logic    miscSel,
    input  logic    wrPulse,
    input  logic    miscAccessStart,
    input  logic    resetReadStart,
    output regWordT miscReadWord,
    output logic    softReset
);

    typedef enum logic [1:0] {idle, arm, stretch} resetStateT;

    resetStateT resetState;
    logic [2:0] stretchCount;
    regOffsetT  offset;
    logic       clockWrite;
    logic       startLevel;
    logic       sc0;
    logic       sc1;
    logic       counterClear;
    regWordT    clockCounter;
    regWordT    clockHold;

    assign offset     = offsetOf(regAddr);
    // Low half of the clock offset starts the stopwatch
    assign clockWrite = wrPulse & miscSel & ~regAddr[1] & (offset == miscClockOffset);

    //********************
    // Stopwatch
    //********************
    always_ff @(posedge ck933 or posedge clockCounterEn or posedge counterClear) begin
        if (clockCounterEn || counterClear) begin
            startLevel <= 1'b0;
        end else if (clockWrite) begin
            startLevel <= 1'b1;
        end
    end

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            sc0          <= 1'b0;
            sc1          <= 1'b0;
            counterClear <= 1'b0;
            clockCounter <= '0;
        end else begin
            sc0          <= startLevel;
            sc1          <= sc0;
            counterClear <= sc0 & ~sc1;
            if (counterClear) begin
                clockCounter <= '0;
            end else begin
                clockCounter <= clockCounter + 32'd1;
            end
        end
    end

    // Snapshot at the start of every misc access
    always_ff @(posedge ck933) begin
        if (miscAccessStart) begin
            clockHold <= clockCounter;
        end
    end

    //********************
    // Software reset stretcher
    //********************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            resetState   <= idle;
            stretchCount <= 3'd0;
        end else begin
            case (resetState)
                idle: begin
                    if (resetReadStart) begin
                        resetState <= arm;
                    end
                end
                arm: begin
                    resetState   <= stretch;
                    stretchCount <= resetStretch - 3'd1;
                end
                stretch: begin
                    if (stretchCount == 3'd0) begin
                        resetState <= idle;
                    end else begin
                        stretchCount <= stretchCount - 3'd1;
                    end
                end
                default: resetState <= idle;
            endcase
        end
    end

    assign softReset = (resetState == stretch);

    // Reset offset reads back as zero
    always_comb begin
        case (offset)
            miscVersionOffset: miscReadWord = {versionNumber, 16'h0000};
            miscClockOffset:   miscReadWord = clockHold;
            default:           miscReadWord = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/modeRegs.sv
`default_nettype none

module modeRegs import addressMapPkg::*, demodModePkg::*; (
    input  logic      ck933,
    input  logic      clockCounterEn,
    input  logic      softReset,
    input  regAddrT   regAddr,
    input  busDataT   wrData,
    input  logic      modeSel,
    input  logic      wrPulse,
    output demodModeT demodMode,
    output dacSelT    dac0Select,
    output dacSelT    dac1Select,
    output dacSelT    dac2Select,
    output regWordT   modeReadWord
);

    regOffsetT   offset;
    logic        lowWrite;
    logic [11:0] dacSelReg;

    assign offset   = offsetOf(regAddr);
    assign lowWrite = wrPulse & modeSel & ~regAddr[1];

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            demodMode <= modeLegacy;
            dacSelReg <= '0;
        end else if (softReset) begin
            demodMode <= modeLegacy;
            dacSelReg <= '0;
        end else if (lowWrite) begin
            if (offset == modeOffset) begin
                demodMode <= demodModeT'(wrData[3:0]);
            end
            if (offset == dacSelOffset) begin
                dacSelReg <= wrData[11:0];
            end
        end
    end

    // One nibble per DAC
    assign dac0Select = dacSelReg[3:0];
    assign dac1Select = dacSelReg[7:4];
    assign dac2Select = dacSelReg[11:8];

    always_comb begin
        case (offset)
            modeOffset:   modeReadWord = {28'h0000000, demodMode};
            dacSelOffset: modeReadWord = {20'h00000, dacSelReg};
            default:      modeReadWord = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/readMux.sv
`default_nettype none

module readMux import addressMapPkg::*; (
    input  logic    ck933,
    input  logic    clockCounterEn,
    input  regAddrT regAddr,
    input  logic    miscSel,
    input  logic    modeSel,
    input  logic    rdActive,
    input  regWordT miscReadWord,
    input  regWordT modeReadWord,
    output busDataT dataOut,
    output logic    dataOutEn
);

    regWordT readWord;
    busDataT readHalf;

    // Unmapped spaces read as zero
    always_comb begin
        if (miscSel) begin
            readWord = miscReadWord;
        end else if (modeSel) begin
            readWord = modeReadWord;
        end else begin
            readWord = '0;
        end
    end

    assign readHalf = regAddr[1] ? readWord[31:16] : readWord[15:0];

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dataOut   <= '0;
            dataOutEn <= 1'b0;
        end else begin
            dataOut   <= rdActive ? readHalf : '0;
            dataOutEn <= rdActive;
        end
    end

endmodule

`default_nettype wire

// File: rtl/symbolSelect.sv
`default_nettype none

module symbolSelect import demodModePkg::*; (
    input  logic      ck933,
    input  logic      clockCounterEn,
    input  demodModeT demodMode,
    input  logic      pcmTrellisBit,
    input  logic      pcmTrellisSymEn,
    input  logic      pcmTrellisSym2xEn,
    input  logic      soqpskTrellisBit,
    input  logic      soqpskTrellisSymEn,
    input  logic      soqpskTrellisSym2xEn,
    input  logic      iBit,
    input  logic      qBit,
    input  logic      iSymEn,
    input  logic      iSym2xEn,
    output logic      iData,
    output logic      qData,
    output logic      dataSymEn,
    output logic      dataSym2xEn
);

    logic pcmMode;
    logic trellisMode;
    logic trellisBit;
    logic trellisSymEn;
    logic trellisSym2xEn;

    assign pcmMode     = (demodMode == modePcmTrellis);
    assign trellisMode = pcmMode || (demodMode == modeSoqpsk);

    // Trellis decoder reclock
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            trellisBit     <= 1'b0;
            trellisSymEn   <= 1'b0;
            trellisSym2xEn <= 1'b0;
        end else begin
            trellisBit     <= pcmMode ? pcmTrellisBit : soqpskTrellisBit;
            trellisSymEn   <= pcmMode ? pcmTrellisSymEn : soqpskTrellisSymEn;
            trellisSym2xEn <= pcmMode ? pcmTrellisSym2xEn : soqpskTrellisSym2xEn;
        end
    end

    // Output register, trellis bit feeds both rails
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            iData       <= 1'b0;
            qData       <= 1'b0;
            dataSymEn   <= 1'b0;
            dataSym2xEn <= 1'b0;
        end else begin
            iData       <= trellisMode ? trellisBit : iBit;
            qData       <= trellisMode ? trellisBit : qBit;
            dataSymEn   <= trellisMode ? trellisSymEn : iSymEn;
            dataSym2xEn <= trellisMode ? trellisSym2xEn : iSym2xEn;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dacSelect.sv
`default_nettype none

module dacSelect import demodModePkg::*; (
    input  logic    ck933,
    input  dacSelT  dac0Select,
    input  dacSelT  dac1Select,
    input  dacSelT  dac2Select,
    input  sampleT  trellis0Sample,
    input  sampleT  trellis1Sample,
    input  sampleT  trellis2Sample,
    input  sampleT  demod0Sample,
    input  sampleT  demod1Sample,
    input  sampleT  demod2Sample,
    output dacWordT dac0_d,
    output dacWordT dac1_d,
    output dacWordT dac2_d
);

    // Trellis codes take the trellis sample, all others the demod
    function automatic dacWordT pickSample(
        dacSelT sel,
        sampleT trellisSample,
        sampleT demodSample
    );
        sampleT chosen;
        case (sel)
            dacTrellisI,
            dacTrellisQ,
            dacTrellisPhErr,
            dacTrellisIndex: chosen = trellisSample;
            default:         chosen = demodSample;
        endcase
        // Top 14 bits
        return chosen[17:4];
    endfunction

    always_ff @(posedge ck933) begin
        dac0_d <= pickSample(dac0Select, trellis0Sample, demod0Sample);
        dac1_d <= pickSample(dac1Select, trellis1Sample, demod1Sample);
        dac2_d <= pickSample(dac2Select, trellis2Sample, demod2Sample);
    end

endmodule

`default_nettype wire

// File: rtl/legacyPassThru.sv
`default_nettype none

module legacyPassThru import addressMapPkg::*, demodModePkg::*; #(
    parameter busDataT    versionNumber = 16'h00c2,
    parameter logic [2:0] resetStretch  = 3'd6
) (
    input  logic      ck933,
    input  logic      clockCounterEn,
    // Processor bus
    input  logic      nCs,
    input  logic      nWe,
    input  logic      nRd,
    input  regAddrT   addr,
    input  busDataT   dataIn,
    output busDataT   dataOut,
    output logic      dataOutEn,
    // Mode and DAC selects
    output demodModeT demodMode,
    output dacSelT    dac0Select,
    output dacSelT    dac1Select,
    output dacSelT    dac2Select,
    // Decoder results
    input  logic      pcmTrellisBit,
    input  logic      pcmTrellisSymEn,
    input  logic      pcmTrellisSym2xEn,
    input  logic      soqpskTrellisBit,
    input  logic      soqpskTrellisSymEn,
    input  logic      soqpskTrellisSym2xEn,
    input  logic      iBit,
    input  logic      qBit,
    input  logic      iSymEn,
    input  logic      iSym2xEn,
    input  sampleT    trellis0Sample,
    input  sampleT    trellis1Sample,
    input  sampleT    trellis2Sample,
    input  sampleT    demod0Sample,
    input  sampleT    demod1Sample,
    input  sampleT    demod2Sample,
    // Data and DAC outputs
    output logic      iData,
    output logic      qData,
    output logic      dataSymEn,
    output logic      dataSym2xEn,
    output dacWordT   dac0_d,
    output dacWordT   dac1_d,
    output dacWordT   dac2_d
);

    regAddrT regAddr;
    busDataT wrData;
    logic    miscSel;
    logic    modeSel;
    logic    wrPulse;
    logic    miscAccessStart;
    logic    resetReadStart;
    logic    rdActive;
    logic    softReset;
    regWordT miscReadWord;
    regWordT modeReadWord;

    //********************
    // Register bus
    //********************
    busDecode u_busDecode (.*);

    miscSpace #(
        .versionNumber (versionNumber),
        .resetStretch  (resetStretch)
    ) u_miscSpace (.*);

    modeRegs u_modeRegs (.*);

    readMux u_readMux (.*);

    //********************
    // Output routing by mode and select
    //********************
    symbolSelect u_symbolSelect (.*);

    dacSelect u_dacSelect (.*);

endmodule

`default_nettype wire

// File: bench/stimulusTable.svh
`ifndef STIMULUS_TABLE_SVH
`define STIMULUS_TABLE_SVH

// Columns are mode, dac0/dac1/dac2 select codes,
// pcm {bit, symEn, sym2xEn}, soqpsk {bit, symEn, sym2xEn},
// legacy {iBit, qBit, iSymEn, iSym2xEn},
// expected {iData, qData, dataSymEn, dataSym2xEn}
// and expected DAC source {dac2, dac1, dac0} where 1 means the trellis sample
localparam int numRows = 8;

typedef struct packed {
    demodModeT  mode;
    dacSelT     dac0Sel;
    dacSelT     dac1Sel;
    dacSelT     dac2Sel;
    logic [2:0] pcmIn;
    logic [2:0] soqpskIn;
    logic [3:0] legacyIn;
    logic [3:0] expData;
    logic [2:0] expTrellisDac;
} rowT;

string rowName [numRows];
rowT   rowData [numRows];

task automatic loadRows();
    rowName[0] = "legacy mode";
    rowData[0] = {modeLegacy, 4'd0, 4'd1, 4'd2,
                  3'b111, 3'b111, 4'b1010, 4'b1010, 3'b000};
    rowName[1] = "legacy all low";
    rowData[1] = {modeLegacy, 4'd8, 4'd3, 4'd15,
                  3'b111, 3'b000, 4'b0000, 4'b0000, 3'b001};
    rowName[2] = "pcm bit high";
    rowData[2] = {modePcmTrellis, 4'd9, 4'd10, 4'd11,
                  3'b110, 3'b001, 4'b0101, 4'b1110, 3'b111};
    rowName[3] = "pcm bit low";
    rowData[3] = {modePcmTrellis, 4'd7, 4'd12, 4'd8,
                  3'b011, 3'b100, 4'b1111, 4'b0011, 3'b100};
    // SOQPSK rows carry pcm inputs that differ
    rowName[4] = "soqpsk bit high";
    rowData[4] = {modeSoqpsk, 4'd11, 4'd0, 4'd9,
                  3'b000, 3'b101, 4'b0110, 4'b1101, 3'b101};
    rowName[5] = "soqpsk bit low";
    rowData[5] = {modeSoqpsk, 4'd4, 4'd10, 4'd5,
                  3'b111, 3'b010, 4'b1001, 4'b0010, 3'b010};
    rowName[6] = "multi-h uses legacy";
    rowData[6] = {modeMultiH, 4'd10, 4'd8, 4'd12,
                  3'b111, 3'b111, 4'b0110, 4'b0110, 3'b011};
    rowName[7] = "back to legacy";
    rowData[7] = {modeLegacy, 4'd6, 4'd9, 4'd3,
                  3'b000, 3'b000, 4'b1101, 4'b1101, 3'b010};
endtask

`endif

// File: bench/legacyPassThruTb.sv
`default_nettype none

module legacyPassThruTb import addressMapPkg::*, demodModePkg::*; ();

    localparam busDataT    versionNumber = 16'h1a5c;
    localparam logic [2:0] resetStretch  = 3'd6;
    localparam int         busHold       = 4;
    localparam int         busGap        = 2;
    localparam int         stopwatchGap  = 5;

    //********************
    // Register addresses
    //********************
    localparam regAddrT versionLowAddr  = {miscSpaceTag, miscVersionOffset};
    localparam regAddrT versionHighAddr = {miscSpaceTag, miscVersionOffset | 4'h2};
    localparam regAddrT clockAddr       = {miscSpaceTag, miscClockOffset};
    localparam regAddrT resetAddr       = {miscSpaceTag, miscResetOffset};
    localparam regAddrT modeAddr        = {modeSpaceTag, modeOffset};
    localparam regAddrT dacSelAddr      = {modeSpaceTag, dacSelOffset};
    localparam regAddrT unmappedAddr    = 12'h3a4;

    logic      ck933;
    logic      clockCounterEn;
    logic      nCs;
    logic      nWe;
    logic      nRd;
    regAddrT   addr;
    busDataT   dataIn;
    busDataT   dataOut;
    logic      dataOutEn;
    demodModeT demodMode;
    dacSelT    dac0Select;
    dacSelT    dac1Select;
    dacSelT    dac2Select;
    logic      pcmTrellisBit;
    logic      pcmTrellisSymEn;
    logic      pcmTrellisSym2xEn;
    logic      soqpskTrellisBit;
    logic      soqpskTrellisSymEn;
    logic      soqpskTrellisSym2xEn;
    logic      iBit;
    logic      qBit;
    logic      iSymEn;
    logic      iSym2xEn;
    sampleT    trellis0Sample;
    sampleT    trellis1Sample;
    sampleT    trellis2Sample;
    sampleT    demod0Sample;
    sampleT    demod1Sample;
    sampleT    demod2Sample;
    logic      iData;
    logic      qData;
    logic      dataSymEn;
    logic      dataSym2xEn;
    dacWordT   dac0_d;
    dacWordT   dac1_d;
    dacWordT   dac2_d;

    int          cycleCount;
    int          rowIdx;
    busDataT     readData;
    busDataT     firstCount;
    busDataT     countDelta;

`include "stimulusTable.svh"

    // Budget per table row plus the fixed tests
    localparam int cycleLimit = 40 * numRows + 400;

    legacyPassThru #(
        .versionNumber (versionNumber),
        .resetStretch  (resetStretch)
    ) u_legacyPassThru (.*);

    initial begin
        ck933 = 1'b0;
        forever #5 ck933 = ~ck933;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge ck933);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
        $display("Checks failed");
        $fatal(1, "Run stopped by the cycle limit");
    end

    //********************
    // Helpers
    //********************
    task automatic nextCycle();
        @(posedge ck933);
        #1;
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %0h actual %0h", testName, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Address stays put after the strobes release
    task automatic writeReg(input regAddrT a, input busDataT d);
        addr   = a;
        dataIn = d;
        nCs    = 1'b0;
        nWe    = 1'b0;
        repeat (busHold) nextCycle();
        nCs = 1'b1;
        nWe = 1'b1;
        repeat (busGap) nextCycle();
    endtask

    task automatic readReg(input regAddrT a, output busDataT d);
        addr = a;
        nCs  = 1'b0;
        nRd  = 1'b0;
        repeat (busHold) nextCycle();
        checkValue("read data enable", 32'h1, 32'(dataOutEn));
        d   = dataOut;
        nCs = 1'b1;
        nRd = 1'b1;
        repeat (busGap) nextCycle();
    endtask

    function automatic sampleT randomSample();
        logic [31:0] r;
        r = $urandom();
        return r[17:0];
    endfunction

    // DAC word is the sample without its 4 LSBs
    function automatic dacWordT topBits(input sampleT s);
        return s[17:4];
    endfunction

    task automatic applyRow(input int idx);
        rowT     row;
        busDataT readBack;
        row = rowData[idx];
        writeReg(modeAddr, {12'h000, row.mode});
        writeReg(dacSelAddr, {4'h0, row.dac2Sel, row.dac1Sel, row.dac0Sel});
        readReg(modeAddr, readBack);
        checkValue({rowName[idx], " mode readback"}, 32'(row.mode), 32'(readBack));
        readReg(dacSelAddr, readBack);
        checkValue({rowName[idx], " select readback"},
                   32'({row.dac2Sel, row.dac1Sel, row.dac0Sel}), 32'(readBack));
        checkValue({rowName[idx], " mode output"}, 32'(row.mode), 32'(demodMode));
        checkValue({rowName[idx], " dac0 select"}, 32'(row.dac0Sel), 32'(dac0Select));
        checkValue({rowName[idx], " dac1 select"}, 32'(row.dac1Sel), 32'(dac1Select));
        checkValue({rowName[idx], " dac2 select"}, 32'(row.dac2Sel), 32'(dac2Select));
        {pcmTrellisBit, pcmTrellisSymEn, pcmTrellisSym2xEn} = row.pcmIn;
        {soqpskTrellisBit, soqpskTrellisSymEn, soqpskTrellisSym2xEn} = row.soqpskIn;
        {iBit, qBit, iSymEn, iSym2xEn} = row.legacyIn;
        trellis0Sample = randomSample();
        trellis1Sample = randomSample();
        trellis2Sample = randomSample();
        demod0Sample   = randomSample();
        demod1Sample   = randomSample();
        demod2Sample   = randomSample();
        repeat (4) nextCycle();
        checkValue({rowName[idx], " data outputs"}, 32'(row.expData),
                   32'({iData, qData, dataSymEn, dataSym2xEn}));
        checkValue({rowName[idx], " dac0"}, 32'(topBits(row.expTrellisDac[0] ?
                   trellis0Sample : demod0Sample)), 32'(dac0_d));
        checkValue({rowName[idx], " dac1"}, 32'(topBits(row.expTrellisDac[1] ?
                   trellis1Sample : demod1Sample)), 32'(dac1_d));
        checkValue({rowName[idx], " dac2"}, 32'(topBits(row.expTrellisDac[2] ?
                   trellis2Sample : demod2Sample)), 32'(dac2_d));
    endtask

    //********************
    // Test sequence
    //********************
    initial begin
        void'($urandom(68));
        clockCounterEn       = 1'b1;
        nCs                  = 1'b1;
        nWe                  = 1'b1;
        nRd                  = 1'b1;
        addr                 = '0;
        dataIn               = '0;
        pcmTrellisBit        = 1'b0;
        pcmTrellisSymEn      = 1'b0;
        pcmTrellisSym2xEn    = 1'b0;
        soqpskTrellisBit     = 1'b0;
        soqpskTrellisSymEn   = 1'b0;
        soqpskTrellisSym2xEn = 1'b0;
        iBit                 = 1'b0;
        qBit                 = 1'b0;
        iSymEn               = 1'b0;
        iSym2xEn             = 1'b0;
        trellis0Sample       = '0;
        trellis1Sample       = '0;
        trellis2Sample       = '0;
        demod0Sample         = '0;
        demod1Sample         = '0;
        demod2Sample         = '0;
        repeat (3) @(posedge ck933);
        #1;
        clockCounterEn = 1'b0;
        nextCycle();

        // State right after reset
        checkValue("reset data enable", 32'h0, 32'(dataOutEn));
        checkValue("reset symbol enables", 32'h0, 32'({dataSymEn, dataSym2xEn}));
        readReg(modeAddr, readData);
        checkValue("reset mode read", 32'h0, 32'(readData));

        // Version word and unmapped space
        readReg(versionHighAddr, readData);
        checkValue("version upper half", 32'(versionNumber), 32'(readData));
        readReg(versionLowAddr, readData);
        checkValue("version lower half", 32'h0, 32'(readData));
        readReg(unmappedAddr, readData);
        checkValue("unmapped read", 32'h0, 32'(readData));

        loadRows();
        for (rowIdx = 0; rowIdx < numRows; rowIdx++) begin
            applyRow(rowIdx);
        end

        // Wait out the stopwatch clear before the first read
        writeReg(clockAddr, 16'h0001);
        repeat (6) nextCycle();
        readReg(clockAddr, firstCount);
        repeat (stopwatchGap) nextCycle();
        readReg(clockAddr, readData);
        countDelta = readData - firstCount;
        checkValue("stopwatch delta", 32'(busHold + busGap + stopwatchGap), 32'(countDelta));

        // Software reset through a read of the reset offset
        writeReg(modeAddr, {12'h000, modeMultiH});
        readReg(modeAddr, readData);
        checkValue("mode before soft reset", 32'(modeMultiH), 32'(readData));
        readReg(resetAddr, readData);
        checkValue("reset offset read", 32'h0, 32'(readData));
        repeat (12) nextCycle();
        checkValue("mode after soft reset", 32'(modeLegacy), 32'(demodMode));
        readReg(modeAddr, readData);
        checkValue("mode read after soft reset", 32'h0, 32'(readData));

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+bench
rtl/addressMapPkg.sv
rtl/demodModePkg.sv
rtl/busDecode.sv
rtl/miscSpace.sv
rtl/modeRegs.sv
rtl/readMux.sv
rtl/symbolSelect.sv
rtl/dacSelect.sv
rtl/legacyPassThru.sv
bench/legacyPassThruTb.sv
